/* rs_station.f */
+incdir+tests
logic/rs_pkg.sv
logic/rs_wakeup.sv
logic/rs_queue.sv
logic/rs_top.sv
tests/rs_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module rs_tb -f rs_station.f -o rs_sim

out=$(./obj_dir/rs_sim)
echo "$out"

# the last command decides the exit status
echo "$out" | grep -qx "TEST OK"

/* tests/rs_model.svh */
`ifndef RS_MODEL_SVH
`define RS_MODEL_SVH

localparam int MAX_DEPTH = (ADD_DEPTH > MUL_DEPTH) ? ADD_DEPTH : MUL_DEPTH;

// queue 0 is the adder queue, queue 1 the multiplier queue
bit m_busy [2][MAX_DEPTH];
bit m_rdy1 [2][MAX_DEPTH];
bit m_rdy2 [2][MAX_DEPTH];
int m_ps1  [2][MAX_DEPTH];
int m_ps2  [2][MAX_DEPTH];
int m_pd   [2][MAX_DEPTH];
int m_rd   [2][MAX_DEPTH];
int m_rob  [2][MAX_DEPTH];
bit m_wake_v [2];   // result buses as seen one cycle late
int m_wake_t [2];

// lowest ready entry, or lowest free slot when want_ready is low; -1 if none
function automatic int lowest_entry(int q, bit want_ready);
    int idx;
    int depth;
    idx   = -1;
    depth = (q == 0) ? ADD_DEPTH : MUL_DEPTH;
    for (int i = depth - 1; i >= 0; i--)
    begin
        if (want_ready ? (m_busy[q][i] && m_rdy1[q][i] && m_rdy2[q][i]) : !m_busy[q][i])
            idx = i;
    end
    return idx;
endfunction

function automatic bit wake_match(int tag);
    return (m_wake_v[0] && m_wake_t[0] == tag) || (m_wake_v[1] && m_wake_t[1] == tag);
endfunction

// same-cycle bypass against the live buses
function automatic bit live_match(int tag);
    return (cdb_add_valid && int'(cdb_add_tag) == tag)
        || (cdb_mul_valid && int'(cdb_mul_tag) == tag);
endfunction

task automatic model_reset();
    for (int q = 0; q < 2; q++)
    begin
        m_wake_v[q] = 1'b0;
        for (int i = 0; i < MAX_DEPTH; i++)
            m_busy[q][i] = 1'b0;
    end
endtask

task automatic model_wakeup(int q);
    for (int i = 0; i < MAX_DEPTH; i++)
    begin
        if (m_busy[q][i] && wake_match(m_ps1[q][i]))
            m_rdy1[q][i] = 1'b1;
        if (m_busy[q][i] && wake_match(m_ps2[q][i]))
            m_rdy2[q][i] = 1'b1;
    end
endtask

task automatic model_insert(int q, int slot);
    m_busy[q][slot] = 1'b1;
    m_ps1[q][slot]  = int'(ps1);
    m_ps2[q][slot]  = int'(ps2);
    m_rdy1[q][slot] = ps1_ready || live_match(int'(ps1));
    m_rdy2[q][slot] = ps2_ready || live_match(int'(ps2));
    m_pd[q][slot]   = int'(pd);
    m_rd[q][slot]   = int'(rd);
    m_rob[q][slot]  = int'(rob_idx);
endtask

// one clock edge; pick and free slot both come from the state before it
task automatic model_edge();
    int pick [2];
    int slot [2];
    for (int q = 0; q < 2; q++)
    begin
        pick[q] = lowest_entry(q, 1'b1);
        slot[q] = lowest_entry(q, 1'b0);
        model_wakeup(q);
    end
    if (pick[0] >= 0 && !add_fu_busy)
        m_busy[0][pick[0]] = 1'b0;
    if (pick[1] >= 0 && !mul_fu_busy)
        m_busy[1][pick[1]] = 1'b0;
    if (dispatch_valid)
        model_insert(int'(queue_sel), slot[int'(queue_sel)]);
    m_wake_v[0] = cdb_add_valid;
    m_wake_t[0] = int'(cdb_add_tag);
    m_wake_v[1] = cdb_mul_valid;
    m_wake_t[1] = int'(cdb_mul_tag);
endtask

`endif

/* tests/rs_tb.sv */
`timescale 1ns/100ps

module rs_tb;

    localparam int ADD_DEPTH     = 4;
    localparam int MUL_DEPTH     = 4;
    localparam int RANDOM_CYCLES = 2000;
    // reset, about 40 directed cycles, random mix, margin
    localparam int RUN_LIMIT     = 16 + 40 + RANDOM_CYCLES + 200;

    logic               clk;
    logic               rst;
    logic               dispatch_valid;
    rs_pkg::queue_sel_t queue_sel;
    rs_pkg::preg_t      ps1, ps2, pd;
    logic               ps1_ready, ps2_ready;
    rs_pkg::areg_t      rd;
    rs_pkg::rob_idx_t   rob_idx;
    logic               cdb_add_valid, cdb_mul_valid;
    rs_pkg::preg_t      cdb_add_tag, cdb_mul_tag;
    logic               add_fu_busy, mul_fu_busy;
    logic               add_fu_ready, mul_fu_ready, add_full, mul_full;
    rs_pkg::preg_t      add_ps1, add_ps2, add_pd, mul_ps1, mul_ps2, mul_pd;
    rs_pkg::areg_t      add_rd, mul_rd;
    rs_pkg::rob_idx_t   add_rob_idx, mul_rob_idx;

    string test_name;
    int    test_errors = 0;
    int    errors = 0;
    int    checks = 0;
    int    tests_run = 0;
    int    tests_failed = 0;
    int    cycles = 0;

    `include "rs_model.svh"

    rs_top #(.ADD_DEPTH(ADD_DEPTH), .MUL_DEPTH(MUL_DEPTH)) u_dut (.*);

    task automatic check_val(string sig, int exp, int act);
        checks++;
        if (exp != act)
        begin
            errors++;
            test_errors++;
            $display("[ERROR] %s %s: expected %0d actual %0d", test_name, sig, exp, act);
        end
    endtask

    // expected outputs of one queue from the model state
    task automatic check_queue(int q, string pfx, logic rdy, rs_pkg::preg_t s1,
                               rs_pkg::preg_t s2, rs_pkg::preg_t d, rs_pkg::areg_t r,
                               rs_pkg::rob_idx_t rob, logic f, logic unit_busy);
        int i;
        bit go;
        i  = lowest_entry(q, 1'b1);
        go = (i >= 0) && !unit_busy;
        check_val({pfx, "_fu_ready"}, int'(go), int'(rdy));
        check_val({pfx, "_ps1"}, go ? m_ps1[q][i] : 0, int'(s1));
        check_val({pfx, "_ps2"}, go ? m_ps2[q][i] : 0, int'(s2));
        check_val({pfx, "_pd"}, go ? m_pd[q][i] : 0, int'(d));
        check_val({pfx, "_rd"}, go ? m_rd[q][i] : 0, int'(r));
        check_val({pfx, "_rob_idx"}, go ? m_rob[q][i] : 0, int'(rob));
        check_val({pfx, "_full"}, int'(lowest_entry(q, 1'b0) < 0), int'(f));
    endtask

    // called at the falling edge, returns just after the next rising edge
    task automatic finish_cycle();
        check_queue(0, "add", add_fu_ready, add_ps1, add_ps2, add_pd, add_rd, add_rob_idx,
                    add_full, add_fu_busy);
        check_queue(1, "mul", mul_fu_ready, mul_ps1, mul_ps2, mul_pd, mul_rd, mul_rob_idx,
                    mul_full, mul_fu_busy);
        model_edge();
        @(posedge clk);
    endtask

    task automatic cycle();
        @(negedge clk);
        finish_cycle();
    endtask

    task automatic dispatch(rs_pkg::queue_sel_t sel, int s1, int s2, bit r1, bit r2, int d);
        dispatch_valid <= 1'b1;
        queue_sel      <= sel;
        ps1            <= rs_pkg::preg_t'(s1);
        ps2            <= rs_pkg::preg_t'(s2);
        ps1_ready      <= r1;
        ps2_ready      <= r2;
        pd             <= rs_pkg::preg_t'(d);
        rd             <= rs_pkg::areg_t'(d);
        rob_idx        <= rs_pkg::rob_idx_t'(d + 1);
    endtask

    task automatic broadcast(bit on_mul, int tag);
        if (on_mul)
        begin
            cdb_mul_valid <= 1'b1;
            cdb_mul_tag   <= rs_pkg::preg_t'(tag);
        end
        else
        begin
            cdb_add_valid <= 1'b1;
            cdb_add_tag   <= rs_pkg::preg_t'(tag);
        end
    endtask

    task automatic idle();
        dispatch_valid <= 1'b0;
        cdb_add_valid  <= 1'b0;
        cdb_mul_valid  <= 1'b0;
    endtask

    task automatic hold_units(bit add_b, bit mul_b);
        add_fu_busy <= add_b;
        mul_fu_busy <= mul_b;
    endtask

    task automatic clear_inputs();
        idle();
        hold_units(1'b0, 1'b0);
        dispatch(rs_pkg::SEL_ADD, 0, 0, 1'b0, 1'b0, 0);
        dispatch_valid <= 1'b0;
        cdb_add_tag    <= '0;
        cdb_mul_tag    <= '0;
    endtask

    task automatic release_reset();
        rst <= 1'b0;
    endtask

    // small tag range so wakeups and bypasses hit often
    task automatic random_inputs();
        rs_pkg::queue_sel_t sel;
        sel = rs_pkg::queue_sel_t'($urandom_range(1));
        dispatch(sel, $urandom_range(7), $urandom_range(7), 1'($urandom_range(1)),
                 1'($urandom_range(1)), $urandom_range(63));
        if (lowest_entry(int'(sel), 1'b0) < 0 || $urandom_range(3) == 0)
            dispatch_valid <= 1'b0;   // never toward a full queue
        cdb_add_valid <= 1'($urandom_range(1));
        cdb_add_tag   <= rs_pkg::preg_t'($urandom_range(7));
        cdb_mul_valid <= 1'($urandom_range(1));
        cdb_mul_tag   <= rs_pkg::preg_t'($urandom_range(7));
        hold_units($urandom_range(3) == 0, $urandom_range(3) == 0);
    endtask

    task automatic end_test();
        tests_run++;
        if (test_errors != 0)
            tests_failed++;
        $display("%-14s %s (%0d errors)", test_name, test_errors == 0 ? "passed" : "failed",
                 test_errors);
        test_errors = 0;
    endtask

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (cycles == RUN_LIMIT)
        begin
            $display("timeout: run did not finish within %0d cycles", RUN_LIMIT);
            $display("TEST FAILED");
            $finish;
        end
    end

    initial
    begin
        void'($urandom(32'h6cb6f853));
        rst = 1'b1;
        clear_inputs();
        repeat (16) @(posedge clk);
        release_reset();
        model_reset();

        test_name = "direct_issue";
        dispatch(rs_pkg::SEL_ADD, 1, 2, 1'b1, 1'b1, 20);
        cycle();
        idle();
        @(negedge clk);
        check_val("add_fu_ready", 1, int'(add_fu_ready));
        check_val("add_pd", 20, int'(add_pd));
        check_val("add_rob_idx", 21, int'(add_rob_idx));
        finish_cycle();
        end_test();

        test_name = "full_flag";
        for (int i = 0; i < ADD_DEPTH; i++)
        begin
            dispatch(rs_pkg::SEL_ADD, 40 + i, 50, 1'b0, 1'b1, 30 + i);
            cycle();
        end
        idle();
        @(negedge clk);
        check_val("add_full", 1, int'(add_full));
        finish_cycle();
        broadcast(1'b0, 40);   // wakes slot 0 only
        cycle();
        idle();
        cycle();
        @(negedge clk);
        check_val("add_pd", 30, int'(add_pd));
        finish_cycle();
        @(negedge clk);
        check_val("add_full", 0, int'(add_full));
        finish_cycle();
        for (int i = 1; i < ADD_DEPTH; i++)
        begin
            broadcast(1'b0, 40 + i);
            cycle();
        end
        idle();
        repeat (ADD_DEPTH + 2) cycle();
        end_test();

        test_name = "wakeup";
        dispatch(rs_pkg::SEL_MUL, 30, 5, 1'b0, 1'b1, 7);
        cycle();
        idle();
        broadcast(1'b1, 30);
        cycle();
        idle();
        @(negedge clk);
        check_val("mul_fu_ready", 0, int'(mul_fu_ready));   // one cycle after the broadcast
        finish_cycle();
        @(negedge clk);
        check_val("mul_fu_ready", 1, int'(mul_fu_ready));
        check_val("mul_pd", 7, int'(mul_pd));
        finish_cycle();
        dispatch(rs_pkg::SEL_ADD, 31, 32, 1'b0, 1'b0, 9);
        broadcast(1'b0, 31);
        broadcast(1'b1, 32);
        cycle();
        idle();
        @(negedge clk);
        check_val("add_fu_ready", 1, int'(add_fu_ready));
        check_val("add_pd", 9, int'(add_pd));
        finish_cycle();
        end_test();

        test_name = "back_pressure";
        hold_units(1'b0, 1'b1);
        for (int i = 0; i < 3; i++)
        begin
            dispatch(rs_pkg::SEL_MUL, 1, 2, 1'b1, 1'b1, 60 + i);
            cycle();
        end
        idle();
        repeat (2)
        begin
            @(negedge clk);
            check_val("mul_fu_ready", 0, int'(mul_fu_ready));
            finish_cycle();
        end
        hold_units(1'b0, 1'b0);
        for (int i = 0; i < 3; i++)
        begin
            @(negedge clk);
            check_val("mul_pd", 60 + i, int'(mul_pd));
            finish_cycle();
        end
        end_test();

        test_name = "random_mix";
        repeat (RANDOM_CYCLES)
        begin
            random_inputs();
            cycle();
        end
        clear_inputs();
        cycle();
        end_test();

        $display("%0d tests, %0d failed, %0d checks, %0d errors", tests_run, tests_failed,
                 checks, errors);
        if (errors == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

/* logic/rs_top.sv */
`timescale 1ns/100ps

module rs_top
    #(
        parameter int ADD_DEPTH = 4,
        parameter int MUL_DEPTH = 4
    )
    (
        input  logic               clk,
        input  logic               rst,

        // dispatch
        input  logic               dispatch_valid,
        input  rs_pkg::queue_sel_t queue_sel,
        input  rs_pkg::preg_t      ps1,
        input  rs_pkg::preg_t      ps2,
        input  logic               ps1_ready,
        input  logic               ps2_ready,
        input  rs_pkg::preg_t      pd,
        input  rs_pkg::areg_t      rd,
        input  rs_pkg::rob_idx_t   rob_idx,

        // result buses
        input  logic               cdb_add_valid,
        input  rs_pkg::preg_t      cdb_add_tag,
        input  logic               cdb_mul_valid,
        input  rs_pkg::preg_t      cdb_mul_tag,

        input  logic               add_fu_busy,
        input  logic               mul_fu_busy,

        // adder issue
        output logic               add_fu_ready,
        output rs_pkg::preg_t      add_ps1,
        output rs_pkg::preg_t      add_ps2,
        output rs_pkg::preg_t      add_pd,
        output rs_pkg::areg_t      add_rd,
        output rs_pkg::rob_idx_t   add_rob_idx,

        // multiplier issue
        output logic               mul_fu_ready,
        output rs_pkg::preg_t      mul_ps1,
        output rs_pkg::preg_t      mul_ps2,
        output rs_pkg::preg_t      mul_pd,
        output rs_pkg::areg_t      mul_rd,
        output rs_pkg::rob_idx_t   mul_rob_idx,

        output logic               add_full,
        output logic               mul_full
    );

    logic          add_insert;
    logic          mul_insert;
    logic          wake_add_valid;
    rs_pkg::preg_t wake_add_tag;
    logic          wake_mul_valid;
    rs_pkg::preg_t wake_mul_tag;
    logic          ps1_ready_eff;
    logic          ps2_ready_eff;

    // one insert strobe per queue
    assign add_insert = dispatch_valid && (queue_sel == rs_pkg::SEL_ADD);
    assign mul_insert = dispatch_valid && (queue_sel == rs_pkg::SEL_MUL);

    rs_wakeup u_wakeup (
        .clk            (clk),
        .rst            (rst),
        .cdb_add_valid  (cdb_add_valid),
        .cdb_add_tag    (cdb_add_tag),
        .cdb_mul_valid  (cdb_mul_valid),
        .cdb_mul_tag    (cdb_mul_tag),
        .ps1            (ps1),
        .ps2            (ps2),
        .ps1_ready      (ps1_ready),
        .ps2_ready      (ps2_ready),
        .wake_add_valid (wake_add_valid),
        .wake_add_tag   (wake_add_tag),
        .wake_mul_valid (wake_mul_valid),
        .wake_mul_tag   (wake_mul_tag),
        .ps1_ready_eff  (ps1_ready_eff),
        .ps2_ready_eff  (ps2_ready_eff)
    );

    rs_queue #(.DEPTH(ADD_DEPTH)) u_add_queue (
        .clk            (clk),
        .rst            (rst),
        .insert         (add_insert),
        .ps1            (ps1),
        .ps2            (ps2),
        .ps1_ready      (ps1_ready_eff),
        .ps2_ready      (ps2_ready_eff),
        .pd             (pd),
        .rd             (rd),
        .rob_idx        (rob_idx),
        .wake_add_valid (wake_add_valid),
        .wake_add_tag   (wake_add_tag),
        .wake_mul_valid (wake_mul_valid),
        .wake_mul_tag   (wake_mul_tag),
        .fu_busy        (add_fu_busy),
        .fu_ready       (add_fu_ready),
        .issue_ps1      (add_ps1),
        .issue_ps2      (add_ps2),
        .issue_pd       (add_pd),
        .issue_rd       (add_rd),
        .issue_rob_idx  (add_rob_idx),
        .full           (add_full)
    );

    rs_queue #(.DEPTH(MUL_DEPTH)) u_mul_queue (
        .clk            (clk),
        .rst            (rst),
        .insert         (mul_insert),
        .ps1            (ps1),
        .ps2            (ps2),
        .ps1_ready      (ps1_ready_eff),
        .ps2_ready      (ps2_ready_eff),
        .pd             (pd),
        .rd             (rd),
        .rob_idx        (rob_idx),
        .wake_add_valid (wake_add_valid),
        .wake_add_tag   (wake_add_tag),
        .wake_mul_valid (wake_mul_valid),
        .wake_mul_tag   (wake_mul_tag),
        .fu_busy        (mul_fu_busy),
        .fu_ready       (mul_fu_ready),
        .issue_ps1      (mul_ps1),
        .issue_ps2      (mul_ps2),
        .issue_pd       (mul_pd),
        .issue_rd       (mul_rd),
        .issue_rob_idx  (mul_rob_idx),
        .full           (mul_full)
    );

endmodule

/* logic/rs_queue.sv */
`timescale 1ns/100ps

module rs_queue
    #(
        parameter int DEPTH = 4
    )
    (
        input  logic             clk,
        input  logic             rst,

        // dispatch side
        input  logic             insert,
        input  rs_pkg::preg_t    ps1,
        input  rs_pkg::preg_t    ps2,
        input  logic             ps1_ready,
        input  logic             ps2_ready,
        input  rs_pkg::preg_t    pd,
        input  rs_pkg::areg_t    rd,
        input  rs_pkg::rob_idx_t rob_idx,

        // registered result buses
        input  logic             wake_add_valid,
        input  rs_pkg::preg_t    wake_add_tag,
        input  logic             wake_mul_valid,
        input  rs_pkg::preg_t    wake_mul_tag,

        // functional unit side
        input  logic             fu_busy,
        output logic             fu_ready,
        output rs_pkg::preg_t    issue_ps1,
        output rs_pkg::preg_t    issue_ps2,
        output rs_pkg::preg_t    issue_pd,
        output rs_pkg::areg_t    issue_rd,
        output rs_pkg::rob_idx_t issue_rob_idx,

        output logic             full
    );

    localparam int IDX_W = $clog2(DEPTH);

    // entry state
    logic [DEPTH-1:0]  busy_q;
    logic [DEPTH-1:0]  rdy1_q;
    logic [DEPTH-1:0]  rdy2_q;
    rs_pkg::preg_t     ps1_q [DEPTH];
    rs_pkg::preg_t     ps2_q [DEPTH];
    rs_pkg::preg_t     pd_q  [DEPTH];
    rs_pkg::areg_t     rd_q  [DEPTH];
    rs_pkg::rob_idx_t  rob_q [DEPTH];

    logic [DEPTH-1:0]  hit1;
    logic [DEPTH-1:0]  hit2;
    logic [DEPTH-1:0]  eligible;
    logic [IDX_W-1:0]  free_idx;
    logic [IDX_W-1:0]  pick_idx;
    logic              pick_valid;

    // tag compare per entry against both registered buses
    for (genvar i = 0; i < DEPTH; i++)
    begin : g_match
        assign hit1[i] = (wake_add_valid && (wake_add_tag == ps1_q[i]))
                      || (wake_mul_valid && (wake_mul_tag == ps1_q[i]));
        assign hit2[i] = (wake_add_valid && (wake_add_tag == ps2_q[i]))
                      || (wake_mul_valid && (wake_mul_tag == ps2_q[i]));
    end

    assign eligible = busy_q & rdy1_q & rdy2_q;

    // lowest free slot; scanning downward lets the lowest index win
    always_comb
    begin
        free_idx = '0;
        for (int i = DEPTH - 1; i >= 0; i--)
        begin
            if (!busy_q[i])
                free_idx = IDX_W'(i);
        end
    end

    // lowest ready entry
    always_comb
    begin
        pick_idx   = '0;
        pick_valid = 1'b0;
        for (int i = DEPTH - 1; i >= 0; i--)
        begin
            if (eligible[i])
            begin
                pick_idx   = IDX_W'(i);
                pick_valid = 1'b1;
            end
        end
    end

    assign fu_ready = pick_valid && !fu_busy;
    assign full     = &busy_q;

    // payload only shown while issuing
    assign issue_ps1     = fu_ready ? ps1_q[pick_idx] : '0;
    assign issue_ps2     = fu_ready ? ps2_q[pick_idx] : '0;
    assign issue_pd      = fu_ready ? pd_q[pick_idx]  : '0;
    assign issue_rd      = fu_ready ? rd_q[pick_idx]  : '0;
    assign issue_rob_idx = fu_ready ? rob_q[pick_idx] : '0;

    // occupancy; insert and issue never touch the same slot
    always_ff @(posedge clk)
    begin
        if (rst)
            busy_q <= '0;
        else
        begin
            if (insert)
                busy_q[free_idx] <= 1'b1;
            if (fu_ready)
                busy_q[pick_idx] <= 1'b0;   // freed at end of issue cycle
        end
    end

    always_ff @(posedge clk)
    begin
        for (int i = 0; i < DEPTH; i++)
        begin
            if (busy_q[i] && hit1[i])
                rdy1_q[i] <= 1'b1;
            if (busy_q[i] && hit2[i])
                rdy2_q[i] <= 1'b1;
        end
        if (insert)
        begin
            rdy1_q[free_idx] <= ps1_ready;  // already includes live-bus bypass
            rdy2_q[free_idx] <= ps2_ready;
            ps1_q[free_idx]  <= ps1;
            ps2_q[free_idx]  <= ps2;
            pd_q[free_idx]   <= pd;
            rd_q[free_idx]   <= rd;
            rob_q[free_idx]  <= rob_idx;
        end
    end

    // dispatcher must respect the full flag of this queue
    a_no_insert_when_full: assert property (
        @(posedge clk) disable iff (rst) insert |-> !full
    ) else $error("rs_queue: insert while full");

    // issued slot is empty right after the edge that ends its issue cycle
    a_issued_slot_freed: assert property (
        @(posedge clk) disable iff (rst) fu_ready |=> !busy_q[$past(pick_idx)]
    ) else $error("rs_queue: issued entry still busy");

endmodule

/* logic/rs_wakeup.sv */
`timescale 1ns/100ps

module rs_wakeup
    (
        input  logic          clk,
        input  logic          rst,

        input  logic          cdb_add_valid,
        input  rs_pkg::preg_t cdb_add_tag,
        input  logic          cdb_mul_valid,
        input  rs_pkg::preg_t cdb_mul_tag,

        input  rs_pkg::preg_t ps1,
        input  rs_pkg::preg_t ps2,
        input  logic          ps1_ready,
        input  logic          ps2_ready,

        output logic          wake_add_valid,
        output rs_pkg::preg_t wake_add_tag,
        output logic          wake_mul_valid,
        output rs_pkg::preg_t wake_mul_tag,

        output logic          ps1_ready_eff,
        output logic          ps2_ready_eff
    );

    // delayed copy of both result buses, compared against stored entries
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            wake_add_valid <= 1'b0;
            wake_mul_valid <= 1'b0;
        end
        else
        begin
            wake_add_valid <= cdb_add_valid;
            wake_mul_valid <= cdb_mul_valid;
        end
    end

    always_ff @(posedge clk)
    begin
        wake_add_tag <= cdb_add_tag;   // only meaningful with its valid
        wake_mul_tag <= cdb_mul_tag;
    end

    // bypass: a result on the live bus this cycle counts at dispatch,
    // since the stored-entry compare would only see it next cycle
    assign ps1_ready_eff = ps1_ready
                        || (cdb_add_valid && (cdb_add_tag == ps1))
                        || (cdb_mul_valid && (cdb_mul_tag == ps1));

    assign ps2_ready_eff = ps2_ready
                        || (cdb_add_valid && (cdb_add_tag == ps2))
                        || (cdb_mul_valid && (cdb_mul_tag == ps2));

endmodule

/* logic/rs_pkg.sv */
package rs_pkg;

    // physical register tag
    typedef logic [5:0] preg_t;

    // architectural register number
    typedef logic [4:0] areg_t;

    // reorder buffer slot
    typedef logic [5:0] rob_idx_t;

    // which issue queue a dispatched op goes to
    typedef logic [0:0] queue_sel_t;

    localparam queue_sel_t SEL_ADD = 1'b0;  // adder queue
    localparam queue_sel_t SEL_MUL = 1'b1;  // multiplier queue

endpackage
